//--- common/fp_macros.svh
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// register file geometry
`define FP_REG_COUNT  8
`define FP_REG_ADDR_W 3

// single precision exponent
`define FP_EXP_BIAS   127

// normal range of the biased exponent
`define FP_EXP_MIN    1
`define FP_EXP_MAX    254

`endif

//--- common/fp_pkg.sv
`default_nettype none

package fp_pkg;

    // 5 to 7 are not decoded and behave as nop
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_MUL = 3'd3,
        OP_SLT = 3'd4
    } fp_op_t;

    // intermediate result ahead of range check and packing
    typedef struct packed {
        // sign of the result
        logic              sign;
        // result is exactly zero, sign is ignored
        logic              zero;
        // biased, wide enough to see both ends of the range
        logic signed [9:0] exp;
        // significand with the hidden one at bit 23
        logic [23:0]       mant;
    } fp_unpacked_t;

endpackage

`default_nettype wire

//--- fp_alu/fp_addsub.sv
`default_nettype none

module fp_addsub (
    input  wire [31:0]           operand_a,
    input  wire [31:0]           operand_b,
    input  wire                  subtract,
    output fp_pkg::fp_unpacked_t sum
);

    logic               sign_a;
    logic               sign_b;
    logic [7:0]         exp_a;
    logic [7:0]         exp_b;
    logic [7:0]         exp_big;
    logic [23:0]        mant_a;
    logic [23:0]        mant_b;
    logic [23:0]        align_a;
    logic [23:0]        align_b;
    logic signed [25:0] val_a;
    logic signed [25:0] val_b;
    logic signed [25:0] total;
    logic [24:0]        mag;
    logic [23:0]        norm_mant;
    logic signed [9:0]  norm_exp;

    assign sign_a = operand_a[31];
    // subtraction is addition with the second sign flipped
    assign sign_b = operand_b[31] ^ subtract;
    assign exp_a  = operand_a[30:23];
    assign exp_b  = operand_b[30:23];
    assign mant_a = {1'b1, operand_a[22:0]};
    assign mant_b = {1'b1, operand_b[22:0]};

    // align the smaller operand, bits shifted out are lost
    always_comb begin
        if (exp_a >= exp_b) begin
            exp_big = exp_a;
            align_a = mant_a;
            align_b = mant_b >> (exp_a - exp_b);
        end else begin
            exp_big = exp_b;
            align_a = mant_a >> (exp_b - exp_a);
            align_b = mant_b;
        end
    end

    assign val_a = sign_a ? -$signed({2'b00, align_a}) : $signed({2'b00, align_a});
    assign val_b = sign_b ? -$signed({2'b00, align_b}) : $signed({2'b00, align_b});
    assign total = val_a + val_b;
    assign mag   = total[25] ? 25'(-total) : total[24:0];

    // leading-one search, at most 23 steps left
    always_comb begin
        norm_mant = mag[23:0];
        norm_exp  = $signed({2'b00, exp_big});
        for (int i = 0; i < 23; i++) begin
            if (!norm_mant[23]) begin
                norm_mant = norm_mant << 1;
                norm_exp  = norm_exp - 10'sd1;
            end
        end
    end

    always_comb begin
        sum = '0;
        if (exp_b == 8'd0) begin
            sum.sign = operand_a[31];
            sum.zero = (exp_a == 8'd0);
            sum.exp  = $signed({2'b00, exp_a});
            sum.mant = mant_a;
        end else if (exp_a == 8'd0) begin
            // second operand goes through as stored, even for sub
            sum.sign = operand_b[31];
            sum.exp  = $signed({2'b00, exp_b});
            sum.mant = mant_b;
        end else if (mag == 25'd0) begin
            // exact cancellation
            sum.zero = 1'b1;
        end else if (mag[24]) begin
            sum.sign = total[25];
            sum.exp  = $signed({2'b00, exp_big}) + 10'sd1;
            sum.mant = mag[24:1];
        end else begin
            sum.sign = total[25];
            sum.exp  = norm_exp;
            sum.mant = norm_mant;
        end
    end

endmodule

`default_nettype wire

//--- fp_alu/fp_mul.sv
`default_nettype none

`include "fp_macros.svh"

module fp_mul (
    input  wire [31:0]           operand_a,
    input  wire [31:0]           operand_b,
    output fp_pkg::fp_unpacked_t product
);

    logic [7:0]        exp_a;
    logic [7:0]        exp_b;
    logic [23:0]       mant_a;
    logic [23:0]       mant_b;
    logic [47:0]       full;
    logic signed [9:0] exp_sum;

    assign exp_a  = operand_a[30:23];
    assign exp_b  = operand_b[30:23];
    assign mant_a = {1'b1, operand_a[22:0]};
    assign mant_b = {1'b1, operand_b[22:0]};

    assign full = mant_a * mant_b;

    // bias counted twice in the sum
    assign exp_sum = 10'(int'(exp_a) + int'(exp_b) - `FP_EXP_BIAS);

    always_comb begin
        product = '0;
        if (exp_a == 8'd0 || exp_b == 8'd0) begin
            product.zero = 1'b1;
        end else begin
            product.sign = operand_a[31] ^ operand_b[31];
            // product of two values in [1,2) is below 4, one step is enough
            if (full[47]) begin
                product.exp  = exp_sum + 10'sd1;
                product.mant = full[47:24];
            end else begin
                product.exp  = exp_sum;
                product.mant = full[46:23];
            end
        end
    end

endmodule

`default_nettype wire

//--- fp_alu/fp_alu.sv
`default_nettype none

`include "fp_macros.svh"

module fp_alu (
    input  wire [31:0]          operand_a,
    input  wire [31:0]          operand_b,
    input  wire fp_pkg::fp_op_t op,
    output logic [31:0]         alu_result,
    output logic                alu_overflow,
    output logic                alu_underflow
);

    import fp_pkg::*;

    fp_unpacked_t sum;
    fp_unpacked_t product;
    fp_unpacked_t unp;
    logic         slt_bit;
    logic [23:0]  mant_a;
    logic [23:0]  mant_b;

    fp_addsub i_addsub (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .subtract  (op == OP_SUB),
        .sum       (sum)
    );

    fp_mul i_mul (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .product   (product)
    );

    assign mant_a = {1'b1, operand_a[22:0]};
    assign mant_b = {1'b1, operand_b[22:0]};

    // sign first, then exponent, then significand; negatives compare reversed
    always_comb begin
        if (operand_a[31] != operand_b[31]) begin
            slt_bit = operand_a[31];
        end else if (!operand_a[31]) begin
            if (operand_a[30:23] != operand_b[30:23]) begin
                slt_bit = operand_a[30:23] < operand_b[30:23];
            end else begin
                slt_bit = mant_a < mant_b;
            end
        end else begin
            if (operand_a[30:23] != operand_b[30:23]) begin
                slt_bit = operand_a[30:23] > operand_b[30:23];
            end else begin
                slt_bit = mant_a > mant_b;
            end
        end
    end

    assign unp = (op == OP_MUL) ? product : sum;

    always_comb begin
        alu_result    = operand_a;
        alu_overflow  = 1'b0;
        alu_underflow = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_MUL: begin
                if (unp.zero) begin
                    alu_result = '0;
                end else if (int'(unp.exp) > `FP_EXP_MAX) begin
                    alu_result   = {unp.sign, 8'hff, 23'd0};
                    alu_overflow = 1'b1;
                end else if (int'(unp.exp) < `FP_EXP_MIN) begin
                    // flush to +0
                    alu_result    = '0;
                    alu_underflow = 1'b1;
                end else begin
                    alu_result = {unp.sign, unp.exp[7:0], unp.mant[22:0]};
                end
            end
            OP_SLT: begin
                alu_result = {31'd0, slt_bit};
            end
            default: begin
                alu_result = operand_a;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/fp_regfile.sv
`default_nettype none

`include "fp_macros.svh"

module fp_regfile (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr_en,
    input  wire [`FP_REG_ADDR_W-1:0] wr_addr,
    input  wire [31:0]               wr_data,
    input  wire [`FP_REG_ADDR_W-1:0] rd_addr_a,
    input  wire [`FP_REG_ADDR_W-1:0] rd_addr_b,
    input  wire [`FP_REG_ADDR_W-1:0] peek_addr,
    output logic [31:0]              rd_data_a,
    output logic [31:0]              rd_data_b,
    output logic [31:0]              peek_data
);

    logic [31:0] regs [`FP_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // all reads are combinational
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign peek_data = regs[peek_addr];

endmodule

`default_nettype wire

//--- logic/fp_flags.sv
`default_nettype none

module fp_flags (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  set_overflow,
    input  wire  set_underflow,
    input  wire  flags_clear,
    output logic overflow,
    output logic underflow
);

    // a set in the same cycle as a clear wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (set_overflow) begin
                overflow <= 1'b1;
            end else if (flags_clear) begin
                overflow <= 1'b0;
            end
            if (set_underflow) begin
                underflow <= 1'b1;
            end else if (flags_clear) begin
                underflow <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_unit.sv
`default_nettype none

`include "fp_macros.svh"

module fp_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      load_en,
    input  wire [`FP_REG_ADDR_W-1:0] load_addr,
    input  wire [31:0]               load_data,
    input  wire                      cmd_valid,
    input  wire fp_pkg::fp_op_t      cmd_op,
    input  wire [`FP_REG_ADDR_W-1:0] cmd_rd,
    input  wire [`FP_REG_ADDR_W-1:0] cmd_rs1,
    input  wire [`FP_REG_ADDR_W-1:0] cmd_rs2,
    input  wire                      flags_clear,
    input  wire [`FP_REG_ADDR_W-1:0] peek_addr,
    output logic                     done,
    output logic [31:0]              result,
    output logic [31:0]              peek_data,
    output logic                     overflow,
    output logic                     underflow
);

    logic                      wr_en;
    logic [`FP_REG_ADDR_W-1:0] wr_addr;
    logic [31:0]               wr_data;
    logic [31:0]               operand_a;
    logic [31:0]               operand_b;
    logic [31:0]               alu_result;
    logic                      alu_overflow;
    logic                      alu_underflow;

    // one write port, a command takes it over a load
    assign wr_en   = cmd_valid | load_en;
    assign wr_addr = cmd_valid ? cmd_rd : load_addr;
    assign wr_data = cmd_valid ? alu_result : load_data;

    fp_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (cmd_rs1),
        .rd_addr_b (cmd_rs2),
        .peek_addr (peek_addr),
        .rd_data_a (operand_a),
        .rd_data_b (operand_b),
        .peek_data (peek_data)
    );

    fp_alu i_alu (
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .op            (cmd_op),
        .alu_result    (alu_result),
        .alu_overflow  (alu_overflow),
        .alu_underflow (alu_underflow)
    );

    fp_flags i_flags (
        .clk           (clk),
        .rst_n         (rst_n),
        .set_overflow  (cmd_valid & alu_overflow),
        .set_underflow (cmd_valid & alu_underflow),
        .flags_clear   (flags_clear),
        .overflow      (overflow),
        .underflow     (underflow)
    );

    // result holds until the next command, done is a single pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= cmd_valid;
            if (cmd_valid) begin
                result <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_fp_model.svh
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// 32-bit Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// returns {overflow, underflow, word}
function automatic logic [33:0] pack_result(input logic sign, input int e,
                                            input logic [23:0] mant);
    if (e > `FP_EXP_MAX) begin
        return {2'b10, sign, 8'hff, 23'd0};
    end
    if (e < `FP_EXP_MIN) begin
        return {2'b01, 32'd0};
    end
    return {2'b00, sign, 8'(e), mant[22:0]};
endfunction

function automatic logic [33:0] model_addsub(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub);
    int     ea;
    int     eb;
    int     e;
    longint ma;
    longint mb;
    longint total;
    logic   sign;
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    ma = longint'({1'b1, a[22:0]});
    mb = longint'({1'b1, b[22:0]});
    // zero operand passes the other one through unchanged
    if (eb == 0) begin
        return (ea == 0) ? 34'd0 : pack_result(a[31], ea, 24'(ma));
    end
    if (ea == 0) begin
        return pack_result(b[31], eb, 24'(mb));
    end
    e = (ea > eb) ? ea : eb;
    ma = (e - ea > 24) ? 0 : ma >> (e - ea);
    mb = (e - eb > 24) ? 0 : mb >> (e - eb);
    if (a[31]) begin
        ma = -ma;
    end
    if (b[31] ^ sub) begin
        mb = -mb;
    end
    total = ma + mb;
    if (total == 0) begin
        return 34'd0;
    end
    sign = total < 0;
    if (sign) begin
        total = -total;
    end
    if (total >= (longint'(1) << 24)) begin
        total = total >> 1;
        e = e + 1;
    end
    while (total < (longint'(1) << 23)) begin
        total = total << 1;
        e = e - 1;
    end
    return pack_result(sign, e, 24'(total));
endfunction

function automatic logic [33:0] model_mul(input logic [31:0] a, input logic [31:0] b);
    logic [47:0] p;
    int          e;
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
        return 34'd0;
    end
    p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - `FP_EXP_BIAS;
    if (p[47]) begin
        return pack_result(a[31] ^ b[31], e + 1, p[47:24]);
    end
    return pack_result(a[31] ^ b[31], e, p[46:23]);
endfunction

function automatic logic [31:0] model_slt(input logic [31:0] a, input logic [31:0] b);
    logic lt;
    if (a[31] != b[31]) begin
        return {31'd0, a[31]};
    end
    if (a[30:23] != b[30:23]) begin
        lt = a[30:23] < b[30:23];
    end else begin
        lt = a[22:0] < b[22:0];
    end
    // negative pair, magnitude order flips
    if (a[31] && a[30:0] != b[30:0]) begin
        lt = !lt;
    end
    return {31'd0, lt};
endfunction

function automatic logic [33:0] model_exec(input fp_op_t op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
        OP_ADD:  return model_addsub(a, b, 1'b0);
        OP_SUB:  return model_addsub(a, b, 1'b1);
        OP_MUL:  return model_mul(a, b);
        OP_SLT:  return {2'b00, model_slt(a, b)};
        default: return {2'b00, a};
    endcase
endfunction

`endif

//--- testbench/tb_fp_unit.sv
`default_nettype none

`include "fp_macros.svh"

module tb_fp_unit;

    import fp_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED    = 32'd5;
    localparam int          ADDSUB_ITERS = 60;
    localparam int          MUL_ITERS    = 40;
    localparam int          CMP_ITERS    = 40;
    localparam int          CHAIN_LEN    = 24;
    // loads, peeks and the directed flag cases
    localparam int          FIXED_CYCLES = 80;
    localparam int          STIM_CYCLES  = RESET_CYCLES + FIXED_CYCLES + 5 * ADDSUB_ITERS
                                           + 4 * MUL_ITERS + 5 * CMP_ITERS + CHAIN_LEN;
    localparam int          TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic                      clk;
    logic                      rst_n;
    logic                      load_en;
    logic [`FP_REG_ADDR_W-1:0] load_addr;
    logic [31:0]               load_data;
    logic                      cmd_valid;
    fp_op_t                    cmd_op;
    logic [`FP_REG_ADDR_W-1:0] cmd_rd;
    logic [`FP_REG_ADDR_W-1:0] cmd_rs1;
    logic [`FP_REG_ADDR_W-1:0] cmd_rs2;
    logic                      flags_clear;
    logic [`FP_REG_ADDR_W-1:0] peek_addr;
    logic                      done;
    logic [31:0]               result;
    logic [31:0]               peek_data;
    logic                      overflow;
    logic                      underflow;

    logic [31:0] model_regs [`FP_REG_COUNT];
    logic        model_done;
    logic [31:0] model_result;
    logic        model_ovf;
    logic        model_unf;
    logic [31:0] lfsr_state;
    int          cycle_count;

    `include "tb_fp_model.svh"

    fp_unit i_fp_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_rd      (cmd_rd),
        .cmd_rs1     (cmd_rs1),
        .cmd_rs2     (cmd_rs2),
        .flags_clear (flags_clear),
        .peek_addr   (peek_addr),
        .done        (done),
        .result      (result),
        .peek_data   (peek_data),
        .overflow    (overflow),
        .underflow   (underflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // msb first, one lfsr step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [31:0] rand_float(input int exp_lo, input int exp_span);
        logic        sign;
        logic [7:0]  expo;
        logic [22:0] frac;
        sign = take_bits(1) != 0;
        expo = 8'(exp_lo + int'(take_bits(6)) % exp_span);
        frac = 23'(take_bits(23));
        return {sign, expo, frac};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic issue_load(input logic [`FP_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cmd_valid   = 1'b0;
        flags_clear = 1'b0;
        load_en     = 1'b1;
        load_addr   = addr;
        load_data   = data;
        peek_addr   = addr;
    endtask

    task automatic issue_cmd(input fp_op_t op, input logic [`FP_REG_ADDR_W-1:0] rd,
                             input logic [`FP_REG_ADDR_W-1:0] rs1,
                             input logic [`FP_REG_ADDR_W-1:0] rs2);
        @(negedge clk);
        load_en     = 1'b0;
        flags_clear = 1'b0;
        cmd_valid   = 1'b1;
        cmd_op      = op;
        cmd_rd      = rd;
        cmd_rs1     = rs1;
        cmd_rs2     = rs2;
        peek_addr   = rd;
    endtask

    task automatic idle_peek(input logic [`FP_REG_ADDR_W-1:0] addr);
        @(negedge clk);
        load_en     = 1'b0;
        cmd_valid   = 1'b0;
        flags_clear = 1'b0;
        peek_addr   = addr;
    endtask

    // reference state, operands read before the edge's writes
    always @(posedge clk) begin : model_update
        logic [33:0] outcome;
        if (!rst_n) begin
            for (int i = 0; i < `FP_REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            model_done   = 1'b0;
            model_result = '0;
            model_ovf    = 1'b0;
            model_unf    = 1'b0;
        end else begin
            outcome = model_exec(cmd_op, model_regs[cmd_rs1], model_regs[cmd_rs2]);
            model_done = cmd_valid;
            if (load_en) begin
                model_regs[load_addr] = load_data;
            end
            if (cmd_valid) begin
                model_regs[cmd_rd] = outcome[31:0];
                model_result       = outcome[31:0];
            end
            if (cmd_valid && outcome[33]) begin
                model_ovf = 1'b1;
            end else if (flags_clear) begin
                model_ovf = 1'b0;
            end
            if (cmd_valid && outcome[32]) begin
                model_unf = 1'b1;
            end else if (flags_clear) begin
                model_unf = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #5;
            check_value("done", done, model_done);
            check_value("result", result, model_result);
            check_value("overflow", overflow, model_ovf);
            check_value("underflow", underflow, model_unf);
            check_value("peek_data", peek_data, model_regs[peek_addr]);
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
                $display("Test FAILED");
                $fatal(1, "simulation timed out");
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        lfsr_state  = LFSR_SEED;
        rst_n       = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        cmd_valid   = 1'b0;
        cmd_op      = OP_NOP;
        cmd_rd      = '0;
        cmd_rs1     = '0;
        cmd_rs2     = '0;
        flags_clear = 1'b0;
        peek_addr   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < `FP_REG_COUNT; i++) begin
            idle_peek(3'(i));
        end
        for (int i = 0; i < `FP_REG_COUNT; i++) begin
            issue_load(3'(i), take_bits(32));
        end
        for (int i = 0; i < `FP_REG_COUNT; i++) begin
            idle_peek(3'(i));
        end

        // cancellation, exponent gaps and zero operands
        for (int i = 0; i < ADDSUB_ITERS; i++) begin
            a = rand_float(100, 55);
            b = rand_float(100, 55);
            case (i % 6)
                1: b = a;
                2: b = {~a[31], a[30:0]};
                3: b[30:23] = a[30:23] - 8'(i);
                4: b = '0;
                5: a = '0;
                default: begin end
            endcase
            issue_load(3'd0, a);
            issue_load(3'd1, b);
            issue_cmd(OP_ADD, 3'd2, 3'd0, 3'd1);
            issue_cmd(OP_SUB, 3'd3, 3'd0, 3'd1);
            issue_cmd(OP_SUB, 3'd4, 3'd1, 3'd0);
        end

        for (int i = 0; i < MUL_ITERS; i++) begin
            a = rand_float(100, 55);
            b = rand_float(100, 55);
            if (i % 5 == 3) begin
                b = '0;
            end
            if (i % 5 == 4) begin
                a[30:23] = 8'd0;
            end
            issue_load(3'd0, a);
            issue_load(3'd1, b);
            issue_cmd(OP_MUL, 3'd5, 3'd0, 3'd1);
            issue_cmd(OP_MUL, 3'd6, 3'd1, 3'd0);
        end

        // slt both ways, nop and the undecoded codes
        for (int i = 0; i < CMP_ITERS; i++) begin
            a = rand_float(100, 55);
            b = rand_float(100, 55);
            case (i % 4)
                1: b = a;
                2: b = {~a[31], a[30:0]};
                3: b = {a[31:23], b[22:0]};
                default: begin end
            endcase
            issue_load(3'd0, a);
            issue_load(3'd1, b);
            issue_cmd(OP_SLT, 3'd2, 3'd0, 3'd1);
            issue_cmd(OP_SLT, 3'd3, 3'd1, 3'd0);
            issue_cmd((i % 2 == 0) ? OP_NOP : fp_op_t'(3'd5 + 3'(i % 3)), 3'd4, 3'd0, 3'd1);
        end

        // overflow with a clear in the same cycle
        issue_load(3'd0, {1'b0, 8'd200, 23'(take_bits(23))});
        issue_load(3'd1, {1'b1, 8'd200, 23'(take_bits(23))});
        issue_cmd(OP_MUL, 3'd2, 3'd0, 3'd1);
        flags_clear = 1'b1;
        issue_load(3'd3, {1'b0, 8'd254, 23'h7f_ffff});
        issue_cmd(OP_ADD, 3'd4, 3'd3, 3'd3);
        issue_load(3'd5, {1'b0, 8'd20, 23'(take_bits(23))});
        issue_cmd(OP_MUL, 3'd6, 3'd5, 3'd5);
        for (int i = 0; i < 4; i++) begin
            issue_load(3'd0, rand_float(100, 55));
            issue_cmd(OP_MUL, 3'd7, 3'd0, 3'd0);
        end
        idle_peek(3'd7);
        flags_clear = 1'b1;
        idle_peek(3'd7);

        // every command reads the previous destination
        issue_load(3'd0, rand_float(120, 16));
        issue_load(3'd1, rand_float(120, 16));
        for (int k = 0; k < CHAIN_LEN; k++) begin
            issue_cmd(fp_op_t'(3'(k % 3 + 1)), 3'(2 + k % 6),
                      (k == 0) ? 3'd0 : 3'(2 + (k - 1) % 6), 3'd1);
            if (k == 5) begin
                // same destination as the command, which must win
                load_en   = 1'b1;
                load_addr = 3'(2 + k % 6);
                load_data = take_bits(32);
            end
        end
        idle_peek(3'd7);
        idle_peek(3'd2);
        @(posedge clk);
        #10;
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
+incdir+testbench
common/fp_pkg.sv
fp_alu/fp_addsub.sv
fp_alu/fp_mul.sv
fp_alu/fp_alu.sv
logic/fp_regfile.sv
logic/fp_flags.sv
logic/fp_unit.sv
testbench/tb_fp_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fp_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
